// ==== alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [dataWidth-1:0] yValue,
    input  logic [dataWidth-1:0] busData,
    input  cpuPkg::aluOpE        opcode,
    input  logic                 incPc,
    input  logic                 zIn,
    output cpuPkg::zWordU        zNext
);

    localparam int shWidth = $clog2(dataWidth);

    logic [shWidth-1:0]            shAmt;
    logic [2*dataWidth-1:0]        rotRight;
    logic [2*dataWidth-1:0]        rotLeft;
    logic signed [dataWidth-1:0]   aSigned;
    logic signed [dataWidth-1:0]   bSigned;
    logic signed [2*dataWidth-1:0] aWide;
    logic signed [2*dataWidth-1:0] bWide;
    logic signed [2*dataWidth-1:0] product;

    assign shAmt   = busData[shWidth-1:0];
    assign aSigned = yValue;
    assign bSigned = busData;

    // Doubled word makes rotation a plain shift
    assign rotRight = {yValue, yValue} >> shAmt;
    assign rotLeft  = {yValue, yValue} << shAmt;

    assign aWide   = {{dataWidth{yValue[dataWidth-1]}}, yValue};
    assign bWide   = {{dataWidth{busData[dataWidth-1]}}, busData};
    assign product = aWide * bWide;  // Low 64 bits are exact

    always_comb begin
        zNext = '0;
        if (incPc) begin
            zNext.full[dataWidth-1:0] = busData + 1'b1;
        end else begin
            case (opcode)
                cpuPkg::addOp:
                    zNext.full[dataWidth-1:0] = yValue + busData;
                cpuPkg::subOp:
                    zNext.full[dataWidth-1:0] = yValue - busData;
                cpuPkg::andOp:
                    zNext.full[dataWidth-1:0] = yValue & busData;
                cpuPkg::orOp:
                    zNext.full[dataWidth-1:0] = yValue | busData;
                cpuPkg::rorOp:
                    zNext.full[dataWidth-1:0] = rotRight[dataWidth-1:0];
                cpuPkg::rolOp:
                    zNext.full[dataWidth-1:0] = rotLeft[2*dataWidth-1:dataWidth];
                cpuPkg::shrOp:
                    zNext.full[dataWidth-1:0] = yValue >> shAmt;
                cpuPkg::shraOp:
                    zNext.full[dataWidth-1:0] = aSigned >>> shAmt;
                cpuPkg::shlOp:
                    zNext.full[dataWidth-1:0] = yValue << shAmt;
                cpuPkg::negOp:
                    zNext.full[dataWidth-1:0] = -busData;
                cpuPkg::notOp:
                    zNext.full[dataWidth-1:0] = ~busData;
                cpuPkg::mulOp:
                    zNext.full = product;
                cpuPkg::divOp: begin
                    if (busData == '0) begin
                        zNext.divResult.quotient  = '1;  // Divide by zero
                        zNext.divResult.remainder = yValue;
                    end else begin
                        zNext.divResult.quotient  = aSigned / bSigned;
                        zNext.divResult.remainder = aSigned % bSigned;
                    end
                end
                default:
                    zNext.full[dataWidth-1:0] = busData;  // Pass through
            endcase
        end
    end

    // Opcode must be known whenever Z loads
    opcodeKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        zIn |-> !$isunknown(opcode)
    ) else $error("alu: opcode unknown while zIn is high");

endmodule

// ==== build.f ====
cpuPkg.sv
regCtrlIf.sv
registerFile.sv
alu.sv
specialRegs.sv
busMux.sv
datapath.sv
datapathTb.sv

// ==== busMux.sv ====
`timescale 1ns/1ps

module busMux #(
    parameter int dataWidth = 32,
    parameter int numRegs   = 16
) (
    input logic                 clk,
    input logic                 arstN,
    regCtrlIf.ctrl              rc,
    input logic                 hiOut,
    input logic                 loOut,
    input logic                 zHighOut,
    input logic                 zLowOut,
    input logic                 pcOut,
    input logic                 mdrOut,
    input logic                 inPortOut,
    input logic                 cOut,
    input logic [dataWidth-1:0] hiValue,
    input logic [dataWidth-1:0] loValue,
    input cpuPkg::zWordU        zValue,
    input logic [dataWidth-1:0] pcValue,
    input logic [dataWidth-1:0] mdrValue,
    input logic [dataWidth-1:0] irValue,
    input logic [dataWidth-1:0] inPortValue
);

    logic [dataWidth-1:0] immExt;
    logic [numRegs+7:0]   drivers;

    // Sign-extended immediate from IR
    assign immExt = {{(dataWidth - cpuPkg::immWidth){irValue[cpuPkg::immWidth-1]}},
                     irValue[cpuPkg::immWidth-1:0]};

    assign drivers = {cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut,
                      rc.regOut};

    // Priority follows source numbering with registers first
    always_comb begin
        if (|rc.regOut)
            rc.busData = rc.regData;
        else if (hiOut)
            rc.busData = hiValue;
        else if (loOut)
            rc.busData = loValue;
        else if (zHighOut)
            rc.busData = zValue.full[2*dataWidth-1:dataWidth];
        else if (zLowOut)
            rc.busData = zValue.full[dataWidth-1:0];
        else if (pcOut)
            rc.busData = pcValue;
        else if (mdrOut)
            rc.busData = mdrValue;
        else if (inPortOut)
            rc.busData = inPortValue;
        else if (cOut)
            rc.busData = immExt;
        else
            rc.busData = '0;  // Idle bus
    end

    singleDriver: assert property (
        @(posedge clk) disable iff (!arstN)
        $onehot0(drivers)
    ) else $error("busMux: more than one bus driver active (%b)", drivers);

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    localparam int wordWidth = 32;  // One half of Z
    localparam int opWidth   = 5;
    localparam int immWidth  = 19;  // Immediate in the low IR bits

    // ALU operation codes
    typedef enum logic [opWidth-1:0] {
        addOp  = 5'b00011,
        subOp  = 5'b00100,
        andOp  = 5'b00101,
        orOp   = 5'b00110,
        rorOp  = 5'b00111,
        rolOp  = 5'b01000,
        shrOp  = 5'b01001,
        shraOp = 5'b01010,
        shlOp  = 5'b01011,
        negOp  = 5'b01100,
        notOp  = 5'b01101,
        mulOp  = 5'b01110,
        divOp  = 5'b01111
    } aluOpE;

    // Remainder sits in the upper word
    typedef struct packed {
        logic [wordWidth-1:0] remainder;
        logic [wordWidth-1:0] quotient;
    } divResultT;

    // Z as one 64-bit word or as a divide result
    typedef union packed {
        logic [2*wordWidth-1:0] full;
        divResultT              divResult;
    } zWordU;

endpackage

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath #(
    parameter int dataWidth = 32,
    parameter int numRegs   = 16
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [numRegs-1:0]   regIn,
    input  logic [numRegs-1:0]   regOut,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  logic                 zIn,
    input  logic                 pcIn,
    input  logic                 incPc,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 read,
    input  logic                 irIn,
    input  logic                 yIn,
    input  logic                 inPortIn,
    input  logic                 hiOut,
    input  logic                 loOut,
    input  logic                 zHighOut,
    input  logic                 zLowOut,
    input  logic                 pcOut,
    input  logic                 mdrOut,
    input  logic                 inPortOut,
    input  logic                 cOut,
    input  cpuPkg::aluOpE        opcode,
    input  logic [dataWidth-1:0] mDataIn,
    input  logic [dataWidth-1:0] inPortData,
    output logic [dataWidth-1:0] busData,
    output logic [dataWidth-1:0] marValue,
    output logic [dataWidth-1:0] irValue
);

    logic [dataWidth-1:0] hiValue;
    logic [dataWidth-1:0] loValue;
    logic [dataWidth-1:0] pcValue;
    logic [dataWidth-1:0] mdrValue;
    logic [dataWidth-1:0] yValue;
    logic [dataWidth-1:0] inPortValue;
    cpuPkg::zWordU        zValue;
    cpuPkg::zWordU        zNext;

    regCtrlIf #(.dataWidth(dataWidth), .numRegs(numRegs)) rc ();

    assign rc.regIn  = regIn;
    assign rc.regOut = regOut;
    assign busData   = rc.busData;

    registerFile #(.dataWidth(dataWidth), .numRegs(numRegs)) uRegisterFile (
        .clk   (clk),
        .arstN (arstN),
        .rc    (rc.regs)
    );

    alu #(.dataWidth(dataWidth)) uAlu (
        .clk     (clk),
        .arstN   (arstN),
        .yValue  (yValue),
        .busData (rc.busData),
        .opcode  (opcode),
        .incPc   (incPc),
        .zIn     (zIn),
        .zNext   (zNext)
    );

    specialRegs #(.dataWidth(dataWidth)) uSpecialRegs (
        .clk         (clk),
        .arstN       (arstN),
        .busData     (rc.busData),
        .zNext       (zNext),
        .mDataIn     (mDataIn),
        .inPortData  (inPortData),
        .hiIn        (hiIn),
        .loIn        (loIn),
        .zIn         (zIn),
        .pcIn        (pcIn),
        .marIn       (marIn),
        .mdrIn       (mdrIn),
        .read        (read),
        .irIn        (irIn),
        .yIn         (yIn),
        .inPortIn    (inPortIn),
        .hiValue     (hiValue),
        .loValue     (loValue),
        .zValue      (zValue),
        .pcValue     (pcValue),
        .mdrValue    (mdrValue),
        .marValue    (marValue),
        .irValue     (irValue),
        .yValue      (yValue),
        .inPortValue (inPortValue)
    );

    busMux #(.dataWidth(dataWidth), .numRegs(numRegs)) uBusMux (
        .clk         (clk),
        .arstN       (arstN),
        .rc          (rc.ctrl),
        .hiOut       (hiOut),
        .loOut       (loOut),
        .zHighOut    (zHighOut),
        .zLowOut     (zLowOut),
        .pcOut       (pcOut),
        .mdrOut      (mdrOut),
        .inPortOut   (inPortOut),
        .cOut        (cOut),
        .hiValue     (hiValue),
        .loValue     (loValue),
        .zValue      (zValue),
        .pcValue     (pcValue),
        .mdrValue    (mdrValue),
        .irValue     (irValue),
        .inPortValue (inPortValue)
    );

endmodule

// ==== datapathTb.sv ====
`timescale 1ns/1ps

module datapathTb;

    localparam int maxCycles = 2000;

    logic          clk;
    logic          arstN;
    logic [15:0]   regIn;
    logic [15:0]   regOut;
    logic          hiIn, loIn, zIn, pcIn, incPc, marIn, mdrIn, read, irIn, yIn, inPortIn;
    logic          hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut;
    cpuPkg::aluOpE opcode;
    logic [31:0]   mDataIn;
    logic [31:0]   inPortData;
    logic [31:0]   busData;
    logic [31:0]   marValue;
    logic [31:0]   irValue;

    int errors;
    int checks;
    int seed;

    datapath dut (.*);

    always #20 clk = ~clk;

    // Watchdog
    initial begin
        for (int n = 0; n < maxCycles; n++) begin
            @(posedge clk);
        end
        $display("Timeout: run did not finish within %0d cycles", maxCycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic idle();
        regIn  <= '0;
        regOut <= '0;
        {hiIn, loIn, zIn, pcIn, incPc, marIn, mdrIn, read, irIn, yIn, inPortIn} <= '0;
        {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} <= '0;
    endtask

    // Previous transfer completes at this edge
    task automatic nextCycle();
        @(posedge clk);
        idle();
    endtask

    // Memory word through MDR into a general register
    task automatic loadReg(input int idx, input logic [31:0] value);
        nextCycle();
        mDataIn <= value;
        read    <= 1'b1;
        mdrIn   <= 1'b1;
        nextCycle();
        mdrOut     <= 1'b1;
        regIn[idx] <= 1'b1;
    endtask

    task automatic readReg(input int idx, output logic [31:0] value);
        nextCycle();
        regOut[idx] <= 1'b1;
        @(negedge clk);
        value = busData;
    endtask

    // Reference model of Z from A = Y and B = bus
    function automatic logic [63:0] expectedZ(cpuPkg::aluOpE op, logic [31:0] a,
                                              logic [31:0] b);
        int unsigned s;
        int          sa;
        int          sb;
        longint      prod;
        logic [31:0] low;
        s   = b[4:0];
        sa  = a;
        sb  = b;
        low = b;
        case (op)
            cpuPkg::addOp:  low = a + b;
            cpuPkg::subOp:  low = a - b;
            cpuPkg::andOp:  low = a & b;
            cpuPkg::orOp:   low = a | b;
            cpuPkg::rorOp:  low = (s == 0) ? a : (a >> s) | (a << (32 - s));
            cpuPkg::rolOp:  low = (s == 0) ? a : (a << s) | (a >> (32 - s));
            cpuPkg::shrOp:  low = a >> s;
            cpuPkg::shraOp: low = sa >>> s;
            cpuPkg::shlOp:  low = a << s;
            cpuPkg::negOp:  low = 32'd0 - b;
            cpuPkg::notOp:  low = ~b;
            cpuPkg::mulOp: begin
                prod = longint'(sa) * longint'(sb);
                return prod;
            end
            cpuPkg::divOp: begin
                if (b == 0)
                    return {a, 32'hffff_ffff};
                return {32'(sa % sb), 32'(sa / sb)};
            end
            default: low = b;
        endcase
        return {32'd0, low};
    endfunction

    task automatic aluCheck(input cpuPkg::aluOpE op, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] expected;
        string       name;
        expected = expectedZ(op, a, b);
        name = $sformatf("%s a=%h b=%h", op.name(), a, b);
        loadReg(1, a);
        loadReg(2, b);
        nextCycle();
        regOut[1] <= 1'b1;  // R1 into Y
        yIn       <= 1'b1;
        nextCycle();
        regOut[2] <= 1'b1;
        opcode    <= op;
        zIn       <= 1'b1;
        nextCycle();
        zLowOut <= 1'b1;
        @(negedge clk);
        checkValue({name, " zLow"}, expected[31:0], busData);
        nextCycle();
        zHighOut <= 1'b1;
        @(negedge clk);
        checkValue({name, " zHigh"}, expected[63:32], busData);
    endtask

    task automatic resetTest();
        logic [31:0] value;
        for (int i = 0; i < 16; i++) begin
            readReg(i, value);
            checkValue($sformatf("reset R%0d", i), 32'd0, value);
        end
        nextCycle();
        @(negedge clk);
        checkValue("reset idle bus", 32'd0, busData);
    endtask

    task automatic memLoadTest();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] value;
        first  = $random(seed);
        second = $random(seed);
        loadReg(3, first);
        loadReg(5, second);
        readReg(5, value);
        checkValue("memory load R5", second, value);
        readReg(3, value);
        checkValue("memory load R3 kept", first, value);
        readReg(4, value);
        checkValue("memory load R4 untouched", 32'd0, value);
    endtask

    task automatic twoOperandTest();
        cpuPkg::aluOpE ops [9] = '{cpuPkg::addOp, cpuPkg::subOp, cpuPkg::andOp,
                                   cpuPkg::orOp, cpuPkg::rorOp, cpuPkg::rolOp,
                                   cpuPkg::shrOp, cpuPkg::shraOp, cpuPkg::shlOp};
        foreach (ops[i]) begin
            aluCheck(ops[i], $random(seed), $random(seed));
        end
    endtask

    // Same B under two different Y values
    task automatic unaryTest();
        logic [31:0] b;
        b = $random(seed);
        aluCheck(cpuPkg::negOp, $random(seed), b);
        aluCheck(cpuPkg::negOp, $random(seed), b);
        aluCheck(cpuPkg::notOp, $random(seed), b);
        aluCheck(cpuPkg::notOp, $random(seed), b);
    endtask

    task automatic mulDivTest();
        aluCheck(cpuPkg::mulOp, $random(seed), $random(seed));
        aluCheck(cpuPkg::mulOp, -32'sd3, 32'd7);
        aluCheck(cpuPkg::divOp, $random(seed), $random(seed) & 32'h0000_ffff);
        aluCheck(cpuPkg::divOp, -32'sd7, 32'd2);
        aluCheck(cpuPkg::divOp, $random(seed), 32'd0);  // Divide by zero
    endtask

    task automatic fetchTest();
        logic [31:0] pcStart;
        logic [31:0] nextPc;
        logic [31:0] instr;
        int          immValue;
        pcStart = $random(seed);
        nextPc  = pcStart + 32'd1;
        instr   = $random(seed) | 32'h0004_0000;  // Negative immediate
        immValue = int'(instr << 13) >>> 13;
        nextCycle();
        mDataIn <= pcStart;
        read    <= 1'b1;
        mdrIn   <= 1'b1;
        nextCycle();
        mdrOut <= 1'b1;
        pcIn   <= 1'b1;
        nextCycle();
        pcOut <= 1'b1;
        incPc <= 1'b1;
        marIn <= 1'b1;
        zIn   <= 1'b1;
        nextCycle();
        zLowOut <= 1'b1;
        pcIn    <= 1'b1;
        @(negedge clk);
        checkValue("fetch MAR", pcStart, marValue);
        checkValue("fetch PC plus one on bus", nextPc, busData);
        nextCycle();
        mDataIn <= instr;
        read    <= 1'b1;
        mdrIn   <= 1'b1;
        nextCycle();
        mdrOut <= 1'b1;
        irIn   <= 1'b1;
        nextCycle();
        cOut <= 1'b1;
        @(negedge clk);
        checkValue("fetch IR", instr, irValue);
        checkValue("fetch immediate", immValue, busData);
        nextCycle();
        pcOut <= 1'b1;
        @(negedge clk);
        checkValue("fetch new PC", nextPc, busData);
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        regIn      = '0;
        regOut     = '0;
        {hiIn, loIn, zIn, pcIn, incPc, marIn, mdrIn, read, irIn, yIn, inPortIn} = '0;
        {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} = '0;
        opcode     = cpuPkg::addOp;
        mDataIn    = '0;
        inPortData = '0;
        errors     = 0;
        checks     = 0;
        seed       = 32'h47c397f3;
        for (int n = 0; n < 2; n++) begin
            @(posedge clk);
        end
        arstN <= 1'b1;
        resetTest();
        memLoadTest();
        twoOperandTest();
        unaryTest();
        mulDivTest();
        fetchTest();
        nextCycle();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== regCtrlIf.sv ====
`timescale 1ns/1ps

interface regCtrlIf #(
    parameter int dataWidth = 32,
    parameter int numRegs   = 16
);

    logic [numRegs-1:0]   regIn;    // Load strobes
    logic [numRegs-1:0]   regOut;   // Drive strobes
    logic [dataWidth-1:0] busData;
    logic [dataWidth-1:0] regData;  // Zero when no strobe set

    modport ctrl (
        input  regOut,
        input  regData,
        output busData
    );

    // Register file side
    modport regs (
        input  regIn,
        input  regOut,
        input  busData,
        output regData
    );

endinterface

// ==== registerFile.sv ====
`timescale 1ns/1ps

module registerFile #(
    parameter int dataWidth = 32,
    parameter int numRegs   = 16
) (
    input logic    clk,
    input logic    arstN,
    regCtrlIf.regs rc
);

    logic [dataWidth-1:0] regBank [numRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regBank[i] <= '0;
            end
        end else begin
            // Any number of registers may load in one cycle
            for (int i = 0; i < numRegs; i++) begin
                if (rc.regIn[i]) begin
                    regBank[i] <= rc.busData;
                end
            end
        end
    end

    // Lowest set strobe wins
    always_comb begin
        rc.regData = '0;
        for (int i = numRegs - 1; i >= 0; i--) begin
            if (rc.regOut[i]) begin
                rc.regData = regBank[i];
            end
        end
    end

    regOutOneHot: assert property (
        @(posedge clk) disable iff (!arstN)
        $onehot0(rc.regOut)
    ) else $error("registerFile: more than one regOut strobe set (%b)", rc.regOut);

endmodule

// ==== specialRegs.sv ====
`timescale 1ns/1ps

module specialRegs #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [dataWidth-1:0] busData,
    input  cpuPkg::zWordU        zNext,
    input  logic [dataWidth-1:0] mDataIn,
    input  logic [dataWidth-1:0] inPortData,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  logic                 zIn,
    input  logic                 pcIn,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 read,
    input  logic                 irIn,
    input  logic                 yIn,
    input  logic                 inPortIn,
    output logic [dataWidth-1:0] hiValue,
    output logic [dataWidth-1:0] loValue,
    output cpuPkg::zWordU        zValue,
    output logic [dataWidth-1:0] pcValue,
    output logic [dataWidth-1:0] mdrValue,
    output logic [dataWidth-1:0] marValue,
    output logic [dataWidth-1:0] irValue,
    output logic [dataWidth-1:0] yValue,
    output logic [dataWidth-1:0] inPortValue
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hiValue     <= '0;
            loValue     <= '0;
            zValue      <= '0;
            pcValue     <= '0;
            mdrValue    <= '0;
            marValue    <= '0;
            irValue     <= '0;
            yValue      <= '0;
            inPortValue <= '0;
        end else begin
            if (hiIn)
                hiValue <= busData;
            if (loIn)
                loValue <= busData;
            if (zIn)
                zValue <= zNext;  // Full 64-bit result
            if (pcIn)
                pcValue <= busData;
            if (marIn)
                marValue <= busData;
            // Memory read or bus write
            if (mdrIn)
                mdrValue <= read ? mDataIn : busData;
            if (irIn)
                irValue <= busData;
            if (yIn)
                yValue <= busData;
            if (inPortIn)
                inPortValue <= inPortData;  // Sampled from outside
        end
    end

    readNeedsMdrIn: assert property (
        @(posedge clk) disable iff (!arstN)
        read |-> mdrIn
    ) else $error("specialRegs: read high without mdrIn");

endmodule
